// ==== verilog/conv_num_pkg.sv ====
// Number formats shared by the expand engine and its testbench
// Input words and weights are signed DATA_WIDTH values
// Lane sums and biased sums are signed ACC_WIDTH values
// Requantization keeps accumulator bits OUT_MSB down to FRAC_SHIFT
package conv_num_pkg;

	// Input word, weight and output word width
	localparam int DATA_WIDTH = 16;

	// Accumulator and biased sum width
	// Sign sits in the top bit
	localparam int ACC_WIDTH = 32;

	////////////////////
	// Requant window
	////////////////////

	// Low bits dropped when going back to 16 bits
	localparam int FRAC_SHIFT = 14;

	// Highest accumulator bit that survives
	// Output word is a zero sign bit over bits OUT_MSB..FRAC_SHIFT
	localparam int OUT_MSB = 28;

endpackage

// ==== verilog/expand_cfg_pkg.sv ====
// Geometry and coefficient rules of the fire4 and fire5 3x3 expand layers
// weight_of and bias_of replace weight ROMs and are called by RTL and testbench
package expand_cfg_pkg;

	// One lane per output channel
	localparam int LANES = 8;
	localparam int CHIN = 4;
	localparam int KERNEL_TAPS = 9;
	localparam int TAPS_PER_PIXEL = KERNEL_TAPS * CHIN;
	localparam int WOUT = 4;
	localparam int PIXELS = WOUT * WOUT;

	// Counter also holds the gap state TAPS_PER_PIXEL
	localparam int TAP_ADDR_WIDTH = $clog2(TAPS_PER_PIXEL + 1);

	typedef enum logic {FIRE4, FIRE5} layer_id_t;

	// Small signed weight in -64..63
	function automatic logic signed [conv_num_pkg::DATA_WIDTH-1:0] weight_of(
		input layer_id_t layer,
		input int unsigned tap,
		input int unsigned lane
	);
		int unsigned mix;
		int w;
		mix = tap * 29 + lane * 53 + ((layer == FIRE5) ? 71 : 17);
		// Different scramble per layer
		if (layer == FIRE5) begin
			mix = (mix * 11 + (mix >> 2)) % 128;
		end else begin
			mix = (mix * 7 + (mix >> 3)) % 128;
		end
		w = int'(mix) - 64;
		return w[conv_num_pkg::DATA_WIDTH-1:0];
	endfunction

	// Bias in accumulator units, roughly -2^18..2^18
	function automatic logic signed [conv_num_pkg::ACC_WIDTH-1:0] bias_of(
		input layer_id_t layer,
		input int unsigned lane
	);
		int unsigned step;
		step = (lane * 5 + ((layer == FIRE5) ? 3 : 1)) % 8;
		return int'(step) * 70000 - 250000;
	endfunction

endpackage

// ==== verilog/mac_lane.sv ====
`timescale 1ns/1ps
// Signed multiply-accumulate lane for one output channel
// On mac_en the product of pix and ker is added to acc
// mac_clr together with mac_en loads the product, which starts a new pixel
module mac_lane (
	input  logic clk,
	input  logic rst,
	input  logic mac_en,
	input  logic mac_clr,
	input  logic signed [conv_num_pkg::DATA_WIDTH-1:0] pix,
	input  logic signed [conv_num_pkg::DATA_WIDTH-1:0] ker,
	output logic signed [conv_num_pkg::ACC_WIDTH-1:0] acc
);
	import conv_num_pkg::*;

	logic signed [ACC_WIDTH-1:0] prod;

	// Full precision product, sign extended to accumulator width
	assign prod = pix * ker;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (mac_en) begin
			if (mac_clr) begin
				// First tap of a pixel
				acc <= prod;
			end else begin
				acc <= acc + prod;
			end
		end
	end

	// Sequencer only clears on an accumulate cycle
	assert property (@(posedge clk) disable iff (!rst) mac_clr |-> mac_en)
		else $error("mac_lane: clear without accumulate enable");

endmodule

// ==== verilog/expand_operand_stage.sv ====
`timescale 1ns/1ps
// Operand staging for the lane array
// Picks the running layer's input word and its kernel row for the current tap
// Both are registered together, so the lanes see them one cycle after the take
module expand_operand_stage (
	input  logic clk,
	input  logic rst,
	input  expand_cfg_pkg::layer_id_t active_layer,
	input  logic [expand_cfg_pkg::TAP_ADDR_WIDTH-1:0] tap_addr,
	input  logic signed [conv_num_pkg::DATA_WIDTH-1:0] ifm_4,
	input  logic signed [conv_num_pkg::DATA_WIDTH-1:0] ifm_5,
	output logic signed [conv_num_pkg::DATA_WIDTH-1:0] pix_reg,
	output logic signed [conv_num_pkg::DATA_WIDTH-1:0] kernel_row [expand_cfg_pkg::LANES]
);
	import conv_num_pkg::*;
	import expand_cfg_pkg::*;

	logic signed [DATA_WIDTH-1:0] word_sel;
	logic signed [DATA_WIDTH-1:0] row_sel [LANES];

	////////////////////
	// Layer mux
	////////////////////

	always_comb begin
		word_sel = (active_layer == FIRE5) ? ifm_5 : ifm_4;
		// One weight per lane from the active layer's rule
		for (int i = 0; i < LANES; i++) begin
			row_sel[i] = weight_of(active_layer, tap_addr, i);
		end
	end

	////////////////////
	// Operand register
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pix_reg <= '0;
			for (int i = 0; i < LANES; i++) begin
				kernel_row[i] <= '0;
			end
		end else begin
			// Lanes only use it on mac_en cycles
			pix_reg <= word_sel;
			kernel_row <= row_sel;
		end
	end

endmodule

// ==== verilog/expand_sequencer.sv ====
`timescale 1ns/1ps
// Control for the shared expand lanes
// Runs 36 takes and one gap per pixel for whichever layer is enabled
// Delays the lane strobes past the operand register and counts pixels per layer
// finish_x rises after the last result and drops after the result memory acknowledges
module expand_sequencer (
	input  logic clk,
	input  logic rst,
	input  logic en_fire4,
	input  logic en_fire5,
	input  logic ram_feedback_4,
	input  logic ram_feedback_5,
	output logic ifm_take,
	output logic [expand_cfg_pkg::TAP_ADDR_WIDTH-1:0] tap_addr,
	output logic mac_en,
	output logic mac_clr,
	output logic pix_done,
	output expand_cfg_pkg::layer_id_t active_layer,
	output logic finish_4,
	output logic finish_5
);
	import expand_cfg_pkg::*;

	logic en4_q;
	logic en5_q;
	logic [TAP_ADDR_WIDTH-1:0] tap_cnt;
	logic [$clog2(PIXELS + 1)-1:0] pix_cnt_4;
	logic [$clog2(PIXELS + 1)-1:0] pix_cnt_5;
	logic run_4;
	logic run_5;
	logic layer_run;
	logic last_tap;
	logic mac_last;
	logic done_q;
	logic end_4;
	logic end_5;
	logic fb_4;
	logic fb_5;

	// Registered enables, first take one cycle after enable
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			en4_q <= 1'b0;
			en5_q <= 1'b0;
		end else begin
			en4_q <= en_fire4;
			en5_q <= en_fire5;
		end
	end

	assign active_layer = en5_q ? FIRE5 : FIRE4;

	// A layer runs until all its pixels were taken
	assign run_4 = en4_q && (pix_cnt_4 != PIXELS);
	assign run_5 = en5_q && (pix_cnt_5 != PIXELS);
	assign layer_run = run_4 || run_5;

	assign ifm_take = layer_run && (tap_cnt != TAPS_PER_PIXEL);
	assign tap_addr = tap_cnt;
	assign last_tap = ifm_take && (tap_cnt == TAPS_PER_PIXEL - 1);

	////////////////////
	// Tap and pixel counters
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_cnt <= '0;
		end else if (!layer_run || tap_cnt == TAPS_PER_PIXEL) begin
			// Gap state or idle
			tap_cnt <= '0;
		end else begin
			tap_cnt <= tap_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pix_cnt_4 <= '0;
			pix_cnt_5 <= '0;
		end else if (last_tap) begin
			if (run_5) begin
				pix_cnt_5 <= pix_cnt_5 + 1'b1;
			end else begin
				pix_cnt_4 <= pix_cnt_4 + 1'b1;
			end
		end
	end

	////////////////////
	// Lane strobes
	////////////////////

	// mac_* line up with the operand register, pix_done with the final sum
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mac_en <= 1'b0;
			mac_clr <= 1'b0;
			mac_last <= 1'b0;
			pix_done <= 1'b0;
			done_q <= 1'b0;
		end else begin
			mac_en <= ifm_take;
			mac_clr <= ifm_take && (tap_cnt == '0);
			mac_last <= last_tap;
			pix_done <= mac_last;
			done_q <= pix_done;
		end
	end

	////////////////////
	// Layer end and finish
	////////////////////

	// End is set the cycle after the last result is registered
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			end_4 <= 1'b0;
			end_5 <= 1'b0;
			fb_4 <= 1'b0;
			fb_5 <= 1'b0;
		end else begin
			end_4 <= end_4 || (done_q && pix_cnt_4 == PIXELS);
			end_5 <= end_5 || (done_q && pix_cnt_5 == PIXELS);
			// Acknowledge only counts once the layer is finished
			fb_4 <= fb_4 || (ram_feedback_4 && end_4);
			fb_5 <= fb_5 || (ram_feedback_5 && end_5);
		end
	end

	assign finish_4 = end_4 && !fb_4;
	assign finish_5 = end_5 && !fb_5;

	assert property (@(posedge clk) disable iff (!rst) !(en_fire4 && en_fire5))
		else $error("expand_sequencer: both layer enables high");

	assert property (@(posedge clk) disable iff (!rst)
		ifm_take |-> !((active_layer == FIRE5) ? end_5 : end_4))
		else $error("expand_sequencer: take after layer end");

	// Finish follows the last pixel's pix_done by two cycles
	assert property (@(posedge clk) disable iff (!rst)
		$rose(finish_4) |-> $past(pix_done, 2) && pix_cnt_4 == PIXELS)
		else $error("expand_sequencer: finish_4 without layer end");

	assert property (@(posedge clk) disable iff (!rst)
		$rose(finish_5) |-> $past(pix_done, 2) && pix_cnt_5 == PIXELS)
		else $error("expand_sequencer: finish_5 without layer end");

endmodule

// ==== verilog/bias_requant.sv ====
`timescale 1ns/1ps
// Bias, ReLU and requantization of the lane sums
// On pix_done each lane gets its layer bias and is cut back to 16 bits
// The result lands in the active layer's bank and ofm_valid pulses one cycle
module bias_requant (
	input  logic clk,
	input  logic rst,
	input  logic pix_done,
	input  expand_cfg_pkg::layer_id_t active_layer,
	input  logic signed [conv_num_pkg::ACC_WIDTH-1:0] acc [expand_cfg_pkg::LANES],
	output logic ofm_valid,
	output logic [conv_num_pkg::DATA_WIDTH-1:0] ofm_4 [expand_cfg_pkg::LANES],
	output logic [conv_num_pkg::DATA_WIDTH-1:0] ofm_5 [expand_cfg_pkg::LANES]
);
	import conv_num_pkg::*;
	import expand_cfg_pkg::*;

	logic signed [ACC_WIDTH-1:0] sum [LANES];
	logic [DATA_WIDTH-1:0] word [LANES];

	////////////////////
	// Bias and ReLU
	////////////////////

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			sum[i] = acc[i] + bias_of(active_layer, i);
			if (sum[i][ACC_WIDTH-1]) begin
				// Negative clamps to zero
				word[i] = '0;
			end else begin
				word[i] = {1'b0, sum[i][OUT_MSB:FRAC_SHIFT]};
			end
		end
	end

	////////////////////
	// Output banks
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ofm_valid <= 1'b0;
			for (int i = 0; i < LANES; i++) begin
				ofm_4[i] <= '0;
				ofm_5[i] <= '0;
			end
		end else begin
			ofm_valid <= pix_done;
			if (pix_done) begin
				// Only the running layer's bank changes
				if (active_layer == FIRE5) begin
					ofm_5 <= word;
				end else begin
					ofm_4 <= word;
				end
			end
		end
	end

endmodule

// ==== verilog/fire_expand3_engine.sv ====
`timescale 1ns/1ps
// Top level of the fire4/fire5 3x3 expand engine
// Raise en_fire4 or en_fire5 and feed the matching input stream on ifm_take
// Results appear on ofm_4 or ofm_5 with an ofm_valid pulse per pixel
// finish_x holds until the matching ram_feedback_x pulse
module fire_expand3_engine (
	input  logic clk,
	input  logic rst,
	input  logic en_fire4,
	input  logic en_fire5,
	input  logic signed [conv_num_pkg::DATA_WIDTH-1:0] ifm_4,
	input  logic signed [conv_num_pkg::DATA_WIDTH-1:0] ifm_5,
	input  logic ram_feedback_4,
	input  logic ram_feedback_5,
	output logic ifm_take,
	output logic ofm_valid,
	output logic [conv_num_pkg::DATA_WIDTH-1:0] ofm_4 [expand_cfg_pkg::LANES],
	output logic [conv_num_pkg::DATA_WIDTH-1:0] ofm_5 [expand_cfg_pkg::LANES],
	output logic finish_4,
	output logic finish_5
);
	import conv_num_pkg::*;
	import expand_cfg_pkg::*;

	logic [TAP_ADDR_WIDTH-1:0] tap_addr;
	logic mac_en;
	logic mac_clr;
	logic pix_done;
	layer_id_t active_layer;
	logic signed [DATA_WIDTH-1:0] pix_reg;
	logic signed [DATA_WIDTH-1:0] kernel_row [LANES];
	logic signed [ACC_WIDTH-1:0] acc [LANES];

	expand_sequencer expand_sequencer_inst (
		.clk(clk),
		.rst(rst),
		.en_fire4(en_fire4),
		.en_fire5(en_fire5),
		.ram_feedback_4(ram_feedback_4),
		.ram_feedback_5(ram_feedback_5),
		.ifm_take(ifm_take),
		.tap_addr(tap_addr),
		.mac_en(mac_en),
		.mac_clr(mac_clr),
		.pix_done(pix_done),
		.active_layer(active_layer),
		.finish_4(finish_4),
		.finish_5(finish_5)
	);

	expand_operand_stage expand_operand_stage_inst (
		.clk(clk),
		.rst(rst),
		.active_layer(active_layer),
		.tap_addr(tap_addr),
		.ifm_4(ifm_4),
		.ifm_5(ifm_5),
		.pix_reg(pix_reg),
		.kernel_row(kernel_row)
	);

	// Lane array, one lane per output channel
	for (genvar g = 0; g < LANES; g++) begin : g_lane
		mac_lane mac_lane_inst (
			.clk(clk),
			.rst(rst),
			.mac_en(mac_en),
			.mac_clr(mac_clr),
			.pix(pix_reg),
			.ker(kernel_row[g]),
			.acc(acc[g])
		);
	end

	bias_requant bias_requant_inst (
		.clk(clk),
		.rst(rst),
		.pix_done(pix_done),
		.active_layer(active_layer),
		.acc(acc),
		.ofm_valid(ofm_valid),
		.ofm_4(ofm_4),
		.ofm_5(ofm_5)
	);

endmodule

// ==== sim/fire_expand3_tb.sv ====
`timescale 1ns/1ps
// Self-checking testbench for the fire4/fire5 3x3 expand engine
// Runs fire4 and then fire5, with idle gaps, on random input words from a fixed seed
// A model predicts every pixel's bank and the cycle of its ofm_valid
// finish, ram_feedback and take counts are checked every cycle on the falling edge
module fire_expand3_tb;
	import conv_num_pkg::*;
	import expand_cfg_pkg::*;

	localparam int WORDS_PER_LAYER = PIXELS * TAPS_PER_PIXEL;
	// Three times the length of both layers, plus room for gaps and reset
	localparam int CYCLE_LIMIT = 3 * 2 * PIXELS * (TAPS_PER_PIXEL + 1) + 200;

	logic clk;
	logic rst;
	logic en_fire4;
	logic en_fire5;
	logic signed [DATA_WIDTH-1:0] ifm_4;
	logic signed [DATA_WIDTH-1:0] ifm_5;
	logic ram_feedback_4;
	logic ram_feedback_5;
	logic ifm_take;
	logic ofm_valid;
	logic [DATA_WIDTH-1:0] ofm_4 [LANES];
	logic [DATA_WIDTH-1:0] ofm_5 [LANES];
	logic finish_4;
	logic finish_5;

	// Model state
	int cycle;
	integer seed;
	layer_id_t cur_layer;
	logic layer_active;
	int takes;
	int valid_cnt;
	int fin_due;
	logic fin_exp_4;
	logic fin_exp_5;
	logic fb_pending;
	int word_idx;
	int pix_words [TAPS_PER_PIXEL];
	logic [LANES*DATA_WIDTH-1:0] exp_q [$];
	int due_q [$];
	logic [DATA_WIDTH-1:0] seen_4 [LANES];
	logic [DATA_WIDTH-1:0] seen_5 [LANES];

	fire_expand3_engine fire_expand3_engine_inst (
		.clk(clk),
		.rst(rst),
		.en_fire4(en_fire4),
		.en_fire5(en_fire5),
		.ifm_4(ifm_4),
		.ifm_5(ifm_5),
		.ram_feedback_4(ram_feedback_4),
		.ram_feedback_5(ram_feedback_5),
		.ifm_take(ifm_take),
		.ofm_valid(ofm_valid),
		.ofm_4(ofm_4),
		.ofm_5(ofm_5),
		.finish_4(finish_4),
		.finish_5(finish_5)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopping at first mismatch");
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Sum of word times weight plus bias, ReLU, then bits OUT_MSB..FRAC_SHIFT
	function automatic logic [DATA_WIDTH-1:0] expected_lane(
		input layer_id_t layer,
		input int lane
	);
		longint s;
		logic [63:0] t;
		s = longint'(bias_of(layer, lane));
		for (int k = 0; k < TAPS_PER_PIXEL; k++) begin
			s += longint'(pix_words[k]) * longint'(weight_of(layer, k, lane));
		end
		if (s < 0) begin
			return '0;
		end
		t = s >> FRAC_SHIFT;
		return {1'b0, t[OUT_MSB-FRAC_SHIFT:0]};
	endfunction

	function automatic logic [LANES*DATA_WIDTH-1:0] model_bank(input layer_id_t layer);
		logic [LANES*DATA_WIDTH-1:0] bank;
		for (int l = 0; l < LANES; l++) begin
			bank[l*DATA_WIDTH +: DATA_WIDTH] = expected_lane(layer, l);
		end
		return bank;
	endfunction

	////////////////////
	// Per-cycle checks
	////////////////////

	task automatic check_outputs();
		logic due_now;
		logic [LANES*DATA_WIDTH-1:0] exp_bank;
		logic [DATA_WIDTH-1:0] want;
		due_now = (due_q.size() > 0) && (due_q[0] == cycle);
		// Acknowledge sent last cycle clears the flag
		if (fb_pending) begin
			if (cur_layer == FIRE5) begin
				fin_exp_5 = 1'b0;
			end else begin
				fin_exp_4 = 1'b0;
			end
			fb_pending = 1'b0;
		end
		if (cycle == fin_due) begin
			if (cur_layer == FIRE5) begin
				fin_exp_5 = 1'b1;
			end else begin
				fin_exp_4 = 1'b1;
			end
		end
		assert (finish_4 === fin_exp_4 && finish_5 === fin_exp_5)
			else report_mismatch($sformatf("finish_4/finish_5 are %b%b, expected %b%b",
				finish_4, finish_5, fin_exp_4, fin_exp_5));
		assert (ofm_valid === due_now)
			else report_mismatch($sformatf("ofm_valid is %b, expected %b", ofm_valid, due_now));
		exp_bank = '0;
		if (due_now) begin
			exp_bank = exp_q.pop_front();
			void'(due_q.pop_front());
			valid_cnt++;
			if (valid_cnt == PIXELS) begin
				fin_due = cycle + 1;
			end
		end
		// Banks only change on a valid, and only the running layer's
		for (int l = 0; l < LANES; l++) begin
			want = (due_now && cur_layer == FIRE4) ?
				exp_bank[l*DATA_WIDTH +: DATA_WIDTH] : seen_4[l];
			assert (ofm_4[l] === want)
				else report_mismatch($sformatf("ofm_4 lane %0d is %h, expected %h",
					l, ofm_4[l], want));
			seen_4[l] = want;
			want = (due_now && cur_layer == FIRE5) ?
				exp_bank[l*DATA_WIDTH +: DATA_WIDTH] : seen_5[l];
			assert (ofm_5[l] === want)
				else report_mismatch($sformatf("ofm_5 lane %0d is %h, expected %h",
					l, ofm_5[l], want));
			seen_5[l] = want;
		end
	endtask

	// New word for the coming edge whenever the engine takes one
	task automatic drive_inputs();
		int w;
		int noise;
		if (ifm_take) begin
			assert (layer_active && takes < WORDS_PER_LAYER)
				else report_mismatch($sformatf("ifm_take high after %0d takes", takes));
			w = $random(seed) % 1024;
			noise = $random(seed) % 1024;
			// Idle stream gets noise so a wrong mux shows up
			if (cur_layer == FIRE5) begin
				ifm_5 = w[DATA_WIDTH-1:0];
				ifm_4 = noise[DATA_WIDTH-1:0];
			end else begin
				ifm_4 = w[DATA_WIDTH-1:0];
				ifm_5 = noise[DATA_WIDTH-1:0];
			end
			pix_words[word_idx] = w;
			word_idx++;
			takes++;
			if (word_idx == TAPS_PER_PIXEL) begin
				exp_q.push_back(model_bank(cur_layer));
				due_q.push_back(cycle + 3);
				word_idx = 0;
			end
		end
	endtask

	task automatic tick();
		@(negedge clk);
		cycle++;
		if (cycle > CYCLE_LIMIT) begin
			$display("Run timed out after %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
		check_outputs();
		drive_inputs();
	endtask

	////////////////////
	// Layer sequence
	////////////////////

	task automatic run_layer(input layer_id_t layer);
		int hold;
		cur_layer = layer;
		takes = 0;
		valid_cnt = 0;
		fin_due = -1;
		word_idx = 0;
		layer_active = 1'b1;
		if (layer == FIRE5) begin
			en_fire5 = 1'b1;
		end else begin
			en_fire4 = 1'b1;
		end
		while (layer == FIRE5 ? !finish_5 : !finish_4) begin
			tick();
		end
		// finish must hold until the acknowledge
		hold = 1 + ({$random(seed)} % 8);
		repeat (hold) tick();
		if (layer == FIRE5) begin
			ram_feedback_5 = 1'b1;
		end else begin
			ram_feedback_4 = 1'b1;
		end
		fb_pending = 1'b1;
		tick();
		ram_feedback_4 = 1'b0;
		ram_feedback_5 = 1'b0;
		// Enable still high, no takes allowed
		repeat (8) tick();
		en_fire4 = 1'b0;
		en_fire5 = 1'b0;
		layer_active = 1'b0;
		repeat (12) tick();
	endtask

	initial begin
		seed = 48083;
		rst = 1'b0;
		en_fire4 = 1'b0;
		en_fire5 = 1'b0;
		ifm_4 = '0;
		ifm_5 = '0;
		ram_feedback_4 = 1'b0;
		ram_feedback_5 = 1'b0;
		cycle = 0;
		cur_layer = FIRE4;
		layer_active = 1'b0;
		takes = 0;
		valid_cnt = 0;
		fin_due = -1;
		fin_exp_4 = 1'b0;
		fin_exp_5 = 1'b0;
		fb_pending = 1'b0;
		word_idx = 0;
		for (int l = 0; l < LANES; l++) begin
			seen_4[l] = '0;
			seen_5[l] = '0;
		end
		repeat (5) tick();
		rst = 1'b1;
		// Idle after reset, nothing may move
		repeat (10) tick();
		run_layer(FIRE4);
		run_layer(FIRE5);
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== fire_expand3_engine.f ====
verilog/conv_num_pkg.sv
verilog/expand_cfg_pkg.sv
verilog/mac_lane.sv
verilog/expand_operand_stage.sv
verilog/expand_sequencer.sv
verilog/bias_requant.sv
verilog/fire_expand3_engine.sv
sim/fire_expand3_tb.sv
